/* project.f */
if_pkg.sv
instr_prefetcher.sv
dummy_inserter.sv
if_id_stage.sv
fetch_stage_top.sv
tb_instr_mem.sv
tb_fetch_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fetch_stage
FILELIST  ?= project.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /^ALL TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)

/* tb_fetch_stage.sv */
// Fetch stage testbench
`timescale 1ns/10ps

module tb_fetch_stage;

  localparam int NUM_TESTS = 9;
  localparam int CYCLES_PER_INSTR = 40;

  logic                                clk;
  logic                                rst_n;
  logic                                pc_set_i;
  if_pkg::pc_mux_e                     pc_mux_i;
  logic [if_pkg::XLEN-1:0]             boot_addr_i, jump_target_i, branch_target_i, mepc_i;
  logic [if_pkg::MTVEC_ADDR_WIDTH-1:0] mtvec_addr_i;
  logic [if_pkg::IRQ_ID_WIDTH-1:0]     irq_id_i;
  logic                                csr_mtvec_init_o;
  logic                                halt_if_i, kill_if_i, id_ready_i;
  logic                                dummy_en_i;
  logic [if_pkg::DUMMY_FREQ_WIDTH-1:0] dummy_freq_i;
  logic                                if_busy_o;
  logic                                instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [if_pkg::XLEN-1:0]             instr_addr_o, instr_rdata_i;
  logic                                id_instr_valid_o, id_dummy_o, id_bus_err_o;
  logic [if_pkg::XLEN-1:0]             id_instr_o, id_pc_o;
  logic [31:0]                         err_addr;

  // Test table, one entry per row
  string           test_name     [NUM_TESTS];
  if_pkg::pc_mux_e test_mux      [NUM_TESTS];
  logic [31:0]     test_operand  [NUM_TESTS];
  logic            test_dummy_en [NUM_TESTS];
  logic [3:0]      test_freq     [NUM_TESTS];
  int unsigned     test_stall    [NUM_TESTS];
  int              test_count    [NUM_TESTS];
  logic [31:0]     test_err_addr [NUM_TESTS];

  string cur_name;
  int    error_count;

  fetch_stage_top dut0 (
    .clk(clk), .rst_n(rst_n),
    .pc_set_i(pc_set_i), .pc_mux_i(pc_mux_i), .boot_addr_i(boot_addr_i),
    .jump_target_i(jump_target_i), .branch_target_i(branch_target_i), .mepc_i(mepc_i),
    .mtvec_addr_i(mtvec_addr_i), .irq_id_i(irq_id_i), .csr_mtvec_init_o(csr_mtvec_init_o),
    .halt_if_i(halt_if_i), .kill_if_i(kill_if_i), .dummy_en_i(dummy_en_i),
    .dummy_freq_i(dummy_freq_i), .id_ready_i(id_ready_i), .if_busy_o(if_busy_o),
    .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o), .instr_gnt_i(instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i), .instr_rdata_i(instr_rdata_i), .instr_err_i(instr_err_i),
    .id_instr_valid_o(id_instr_valid_o), .id_instr_o(id_instr_o), .id_pc_o(id_pc_o),
    .id_dummy_o(id_dummy_o), .id_bus_err_o(id_bus_err_o)
  );

  tb_instr_mem mem0 (
    .clk(clk), .rst_n(rst_n), .req_i(instr_req_o), .addr_i(instr_addr_o),
    .gnt_o(instr_gnt_i), .rvalid_o(instr_rvalid_i), .rdata_o(instr_rdata_i),
    .err_o(instr_err_i), .err_addr_i(err_addr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // Fetch target for each redirect source
  function automatic logic [31:0] expected_target(if_pkg::pc_mux_e mux, logic [31:0] op);
    case (mux)
      if_pkg::PC_BOOT:     return {op[31:2], 2'b00};
      if_pkg::PC_TRAP_EXC: return {op[24:0], 7'b0000000};
      if_pkg::PC_TRAP_IRQ: return {op[24:0], op[29:25], 2'b00};
      default:             return op;
    endcase
  endfunction

  // Memory content rule, halves swapped then scrambled
  function automatic logic [31:0] expected_word(logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1;
  endfunction

  task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
    $display("CHECK FAILED test=%s %s expected=%h actual=%h", cur_name, what, exp, act);
    error_count++;
  endtask

  task automatic report_problem(string what);
    $display("ERROR: test %s, %s", cur_name, what);
    error_count++;
  endtask

  task automatic set_row(int idx, string name, if_pkg::pc_mux_e mux, logic [31:0] op,
                         logic en, logic [3:0] freq, int unsigned stall, int count,
                         logic [31:0] err);
    test_name[idx]     = name;
    test_mux[idx]      = mux;
    test_operand[idx]  = op;
    test_dummy_en[idx] = en;
    test_freq[idx]     = freq;
    test_stall[idx]    = stall;
    test_count[idx]    = count;
    test_err_addr[idx] = err;
  endtask

  // Name, source, operand, dummy enable, frequency, stall %, count, error address
  task automatic fill_table();
    set_row(0, "boot",     if_pkg::PC_BOOT,     32'h0000_1003, 0, 0, 0,  20, 32'h1);
    set_row(1, "jump",     if_pkg::PC_JUMP,     32'h0000_2440, 0, 0, 30, 12, 32'h1);
    set_row(2, "branch",   if_pkg::PC_BRANCH,   32'h0000_3A0C, 0, 0, 30, 12, 32'h1);
    set_row(3, "mret",     if_pkg::PC_MRET,     32'h0000_51F8, 0, 0, 30, 12, 32'h1);
    set_row(4, "trap_exc", if_pkg::PC_TRAP_EXC, 32'h0A00_0123, 0, 0, 20, 10, 32'h1);
    set_row(5, "trap_irq", if_pkg::PC_TRAP_IRQ, 32'h1600_0123, 0, 0, 20, 10, 32'h1);
    set_row(6, "stall",    if_pkg::PC_JUMP,     32'h0000_8000, 0, 0, 60, 40, 32'h1);
    set_row(7, "dummy",    if_pkg::PC_JUMP,     32'h0000_9000, 1, 3, 25, 24, 32'h0000_900C);
    set_row(8, "bus_err",  if_pkg::PC_BRANCH,   32'h0000_A000, 0, 0, 25, 12, 32'h0000_A014);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Unselected sources carry distinct values so a wrong pick shows up
  task automatic drive_redirect(int idx);
    logic [31:0] op;
    op              = test_operand[idx];
    boot_addr_i     = 32'hDEAD_0100;
    jump_target_i   = 32'hDEAD_0200;
    branch_target_i = 32'hDEAD_0300;
    mepc_i          = 32'hDEAD_0400;
    mtvec_addr_i    = 25'h0F0_F0F0;
    irq_id_i        = 5'h1F;
    case (test_mux[idx])
      if_pkg::PC_BOOT:   boot_addr_i = op;
      if_pkg::PC_JUMP:   jump_target_i = op;
      if_pkg::PC_BRANCH: branch_target_i = op;
      if_pkg::PC_MRET:   mepc_i = op;
      default: begin
        mtvec_addr_i = op[24:0];
        irq_id_i     = op[29:25];
      end
    endcase
    pc_mux_i = test_mux[idx];
    pc_set_i = 1'b1;
  endtask

  task automatic run_test(int idx);
    logic [31:0] exp_pc;
    logic        exp_dummy;
    int          real_cnt;
    int          since_dummy;
    cur_name = test_name[idx];
    // Empty the IF/ID register under halt before redirecting
    halt_if_i    = 1'b1;
    id_ready_i   = 1'b1;
    dummy_en_i   = test_dummy_en[idx];
    dummy_freq_i = test_freq[idx];
    err_addr     = test_err_addr[idx];
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    if (id_instr_valid_o !== 1'b0) report_problem("IF/ID register still valid under halt");
    drive_redirect(idx);
    @(negedge clk);
    if (csr_mtvec_init_o !== (test_mux[idx] == if_pkg::PC_BOOT))
      report_mismatch("csr_mtvec_init", test_mux[idx] == if_pkg::PC_BOOT, csr_mtvec_init_o);
    @(posedge clk);
    #1;
    pc_set_i    = 1'b0;
    halt_if_i   = 1'b0;
    exp_pc      = expected_target(test_mux[idx], test_operand[idx]);
    real_cnt    = 0;
    // Issue counter sits saturated, so a dummy leads the stream
    since_dummy = int'(test_freq[idx]);
    while (real_cnt < test_count[idx]) begin
      id_ready_i = (($urandom % 100) >= test_stall[idx]);
      @(negedge clk);
      // ID takes the register at the coming edge
      if (id_instr_valid_o && id_ready_i) begin
        exp_dummy = test_dummy_en[idx] && (since_dummy >= int'(test_freq[idx]));
        if (id_dummy_o !== exp_dummy) report_mismatch("id_dummy", exp_dummy, id_dummy_o);
        if (id_dummy_o) begin
          if (id_instr_o[6:0] !== if_pkg::DUMMY_OPCODE)
            report_mismatch("dummy opcode", if_pkg::DUMMY_OPCODE, id_instr_o[6:0]);
          if (id_instr_o[11:7] !== 5'd0) report_mismatch("dummy rd", 0, id_instr_o[11:7]);
          if (id_bus_err_o !== 1'b0) report_mismatch("dummy bus_err", 0, id_bus_err_o);
          since_dummy = 0;
        end else begin
          if (id_pc_o !== exp_pc) report_mismatch("pc", exp_pc, id_pc_o);
          if (id_instr_o !== expected_word(exp_pc))
            report_mismatch("word", expected_word(exp_pc), id_instr_o);
          if (id_bus_err_o !== (exp_pc == test_err_addr[idx]))
            report_mismatch("bus_err", exp_pc == test_err_addr[idx], id_bus_err_o);
          exp_pc = exp_pc + 32'd4;
          real_cnt++;
          since_dummy++;
        end
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    void'($urandom(32'h6c78));
    error_count = 0;
    cur_name    = "reset";
    rst_n       = 1'b0;
    pc_set_i    = 1'b0;
    pc_mux_i    = if_pkg::PC_BOOT;
    boot_addr_i = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i       = '0;
    mtvec_addr_i = '0;
    irq_id_i     = '0;
    halt_if_i    = 1'b0;
    kill_if_i    = 1'b0;
    dummy_en_i   = 1'b0;
    dummy_freq_i = '0;
    id_ready_i   = 1'b0;
    err_addr     = 32'h1;
    fill_table();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    // Idle until the first redirect
    if (instr_req_o || id_instr_valid_o || csr_mtvec_init_o || if_busy_o)
      report_problem("outputs not idle after reset");
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_TESTS; i++) run_test(i);
    $display("Tests run: %0d, errors: %0d", NUM_TESTS, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Budget of cycles per real instruction over the whole table
  initial begin
    int total;
    total = 0;
    @(posedge rst_n);
    for (int i = 0; i < NUM_TESTS; i++) total += test_count[i];
    repeat (total * CYCLES_PER_INSTR) @(posedge clk);
    $display("ERROR: watchdog expired in test %s after %0d errors", cur_name, error_count);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* tb_instr_mem.sv */
// Instruction memory model
`timescale 1ns/10ps

module tb_instr_mem (
  input  logic        clk,
  input  logic        rst_n,
  // Bus request side
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  // Response side
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o,
  // Address that answers with a bus error
  input  logic [31:0] err_addr_i
);

  // Accepted addresses still owed a response, oldest first
  logic [31:0] pending_q [$];

  // Content is a scramble of the whole address
  function automatic logic [31:0] word_at(logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1;
  endfunction

  initial begin
    logic [31:0] addr;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    forever begin
      // Request seen here is the one accepted at the coming edge
      @(negedge clk);
      if (rst_n && req_i && gnt_o) begin
        pending_q.push_back(addr_i);
      end
      @(posedge clk);
      #1;
      // Grant with random delay, about three cycles in four
      gnt_o = rst_n && (($urandom % 4) != 0);
      if (rst_n && (pending_q.size() > 0) && (($urandom % 3) != 0)) begin
        addr     = pending_q.pop_front();
        rvalid_o = 1'b1;
        rdata_o  = word_at(addr);
        err_o    = (addr == err_addr_i);
      end else begin
        rvalid_o = 1'b0;
        rdata_o  = '0;
        err_o    = 1'b0;
      end
    end
  end

endmodule

/* fetch_stage_top.sv */
// Instruction fetch stage top
`timescale 1ns/10ps

module fetch_stage_top (
  input  logic                                clk,
  input  logic                                rst_n,
  // Redirect
  input  logic                                pc_set_i,
  input  if_pkg::pc_mux_e                     pc_mux_i,
  input  logic [if_pkg::XLEN-1:0]             boot_addr_i,
  input  logic [if_pkg::XLEN-1:0]             jump_target_i,
  input  logic [if_pkg::XLEN-1:0]             branch_target_i,
  input  logic [if_pkg::XLEN-1:0]             mepc_i,
  input  logic [if_pkg::MTVEC_ADDR_WIDTH-1:0] mtvec_addr_i,
  input  logic [if_pkg::IRQ_ID_WIDTH-1:0]     irq_id_i,
  output logic                                csr_mtvec_init_o,
  // Stage control and dummy setup
  input  logic                                halt_if_i,
  input  logic                                kill_if_i,
  input  logic                                dummy_en_i,
  input  logic [if_pkg::DUMMY_FREQ_WIDTH-1:0] dummy_freq_i,
  input  logic                                id_ready_i,
  output logic                                if_busy_o,
  // Instruction bus
  output logic                                instr_req_o,
  output logic [if_pkg::XLEN-1:0]             instr_addr_o,
  input  logic                                instr_gnt_i,
  input  logic                                instr_rvalid_i,
  input  logic [if_pkg::XLEN-1:0]             instr_rdata_i,
  input  logic                                instr_err_i,
  // IF/ID register
  output logic                                id_instr_valid_o,
  output logic [if_pkg::XLEN-1:0]             id_instr_o,
  output logic [if_pkg::XLEN-1:0]             id_pc_o,
  output logic                                id_dummy_o,
  output logic                                id_bus_err_o
);

  // Prefetcher to IF/ID
  logic                    fetch_valid;
  logic [if_pkg::XLEN-1:0] fetch_word;
  logic [if_pkg::XLEN-1:0] fetch_pc;
  logic                    fetch_err;
  logic                    fetch_ready;
  // Dummy path
  logic                    dummy_insert;
  logic [if_pkg::XLEN-1:0] dummy_word;
  logic                    instr_issued;

  instr_prefetcher u_prefetcher (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .instr_err_i      (instr_err_i),
    .fetch_valid_o    (fetch_valid),
    .fetch_word_o     (fetch_word),
    .fetch_pc_o       (fetch_pc),
    .fetch_err_o      (fetch_err),
    .fetch_ready_i    (fetch_ready),
    .busy_o           (if_busy_o)
  );

  dummy_inserter u_dummy (
    .clk            (clk),
    .rst_n          (rst_n),
    .dummy_en_i     (dummy_en_i),
    .dummy_freq_i   (dummy_freq_i),
    .instr_issued_i (instr_issued),
    .fetch_valid_i  (fetch_valid),
    .kill_if_i      (kill_if_i),
    .dummy_insert_o (dummy_insert),
    .dummy_word_o   (dummy_word)
  );

  if_id_stage u_if_id (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_valid_i    (fetch_valid),
    .fetch_word_i     (fetch_word),
    .fetch_pc_i       (fetch_pc),
    .fetch_err_i      (fetch_err),
    .fetch_ready_o    (fetch_ready),
    .dummy_insert_i   (dummy_insert),
    .dummy_word_i     (dummy_word),
    .instr_issued_o   (instr_issued),
    .halt_if_i        (halt_if_i),
    .kill_if_i        (kill_if_i),
    .id_ready_i       (id_ready_i),
    .id_instr_valid_o (id_instr_valid_o),
    .id_instr_o       (id_instr_o),
    .id_pc_o          (id_pc_o),
    .id_dummy_o       (id_dummy_o),
    .id_bus_err_o     (id_bus_err_o)
  );

endmodule

/* if_id_stage.sv */
// IF/ID pipeline stage
`timescale 1ns/10ps

module if_id_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  // From prefetcher
  input  logic                    fetch_valid_i,
  input  logic [if_pkg::XLEN-1:0] fetch_word_i,
  input  logic [if_pkg::XLEN-1:0] fetch_pc_i,
  input  logic                    fetch_err_i,
  output logic                    fetch_ready_o,
  // From dummy inserter
  input  logic                    dummy_insert_i,
  input  logic [if_pkg::XLEN-1:0] dummy_word_i,
  output logic                    instr_issued_o,
  // Pipeline control
  input  logic                    halt_if_i,
  input  logic                    kill_if_i,
  input  logic                    id_ready_i,
  // Pipeline register
  output logic                    id_instr_valid_o,
  output logic [if_pkg::XLEN-1:0] id_instr_o,
  output logic [if_pkg::XLEN-1:0] id_pc_o,
  output logic                    id_dummy_o,
  output logic                    id_bus_err_o
);

  logic dummy_sel;
  logic if_valid;
  logic load;
  // Last word loaded was a dummy
  logic dummy_taken_q;

  // One dummy per insertion window
  assign dummy_sel = dummy_insert_i && !dummy_taken_q;

  ////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////

  assign if_valid = (fetch_valid_i || dummy_sel) && !halt_if_i && !kill_if_i;
  assign load     = if_valid && id_ready_i;

  // Kill drains the buffer, a dummy holds the real word back
  assign fetch_ready_o = kill_if_i || (id_ready_i && !halt_if_i && !dummy_sel);

  // Real instructions only
  assign instr_issued_o = load && !dummy_sel;

  ////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_instr_valid_o <= 1'b0;
      id_dummy_o       <= 1'b0;
      id_bus_err_o     <= 1'b0;
      dummy_taken_q    <= 1'b0;
    end else begin
      if (load) begin
        id_instr_valid_o <= 1'b1;
        id_dummy_o       <= dummy_sel;
        // Dummies never carry a bus error
        id_bus_err_o     <= fetch_err_i && !dummy_sel;
        dummy_taken_q    <= dummy_sel;
      end else if (id_ready_i) begin
        id_instr_valid_o <= 1'b0;
      end
    end
  end

  // Dummy keeps the PC of the real instruction it precedes
  always_ff @(posedge clk) begin
    if (load) begin
      id_instr_o <= dummy_sel ? dummy_word_i : fetch_word_i;
      id_pc_o    <= fetch_pc_i;
    end
  end

  // Stalled ID sees a frozen register
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i && id_instr_valid_o |=> id_instr_valid_o && $stable(id_instr_o) &&
      $stable(id_pc_o) && $stable(id_dummy_o) && $stable(id_bus_err_o));

endmodule

/* dummy_inserter.sv */
// Dummy instruction inserter
`timescale 1ns/10ps

module dummy_inserter (
  input  logic                                clk,
  input  logic                                rst_n,
  // Configuration
  input  logic                                dummy_en_i,
  input  logic [if_pkg::DUMMY_FREQ_WIDTH-1:0] dummy_freq_i,
  // Pipeline status
  input  logic                                instr_issued_i,
  input  logic                                fetch_valid_i,
  input  logic                                kill_if_i,
  // Dummy request and word
  output logic                                dummy_insert_o,
  output logic [if_pkg::XLEN-1:0]             dummy_word_o
);

  logic [if_pkg::DUMMY_FREQ_WIDTH-1:0] issued_cnt_q;
  logic                                cnt_reached;
  logic                                dummy_done;
  logic [31:0]                         lfsr_q, lfsr_n;

  // Zero frequency keeps insertion off
  assign cnt_reached = (dummy_freq_i != '0) && (issued_cnt_q >= dummy_freq_i);

  // Only in front of a waiting real instruction
  assign dummy_insert_o = dummy_en_i && cnt_reached && fetch_valid_i && !kill_if_i;

  // Real instruction behind the dummy closes the window
  assign dummy_done = instr_issued_i && cnt_reached;

  ////////////////////////////////////////////////////////////
  // Issue counter and LFSR
  ////////////////////////////////////////////////////////////

  // Galois step, shift right
  assign lfsr_n = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? if_pkg::LFSR_TAPS : 32'h0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issued_cnt_q <= '0;
      lfsr_q       <= if_pkg::LFSR_SEED;
    end else begin
      // Restart counting with the instruction that just issued
      if (dummy_done) begin
        issued_cnt_q <= if_pkg::DUMMY_FREQ_WIDTH'(1);
      end else if (instr_issued_i && (issued_cnt_q != '1)) begin
        issued_cnt_q <= issued_cnt_q + 1'b1;
      end
      // New operands for the next dummy
      if (dummy_done && dummy_en_i) lfsr_q <= lfsr_n;
    end
  end

  // R-type with funct7 zero and rd x0 so every funct3 is legal
  assign dummy_word_o = {7'b0000000,
                         lfsr_q[12:8],
                         lfsr_q[7:3],
                         lfsr_q[2:0],
                         5'b00000,
                         if_pkg::DUMMY_OPCODE};

  // Killed fetch never closes a dummy window
  a_no_dummy_on_kill: assert property (@(posedge clk) disable iff (!rst_n)
    kill_if_i |-> !dummy_done);

endmodule

/* instr_prefetcher.sv */
// Instruction prefetcher
`timescale 1ns/10ps

module instr_prefetcher (
  input  logic                                clk,
  input  logic                                rst_n,
  // Redirect request and target operands
  input  logic                                pc_set_i,
  input  if_pkg::pc_mux_e                     pc_mux_i,
  input  logic [if_pkg::XLEN-1:0]             boot_addr_i,
  input  logic [if_pkg::XLEN-1:0]             jump_target_i,
  input  logic [if_pkg::XLEN-1:0]             branch_target_i,
  input  logic [if_pkg::XLEN-1:0]             mepc_i,
  input  logic [if_pkg::MTVEC_ADDR_WIDTH-1:0] mtvec_addr_i,
  input  logic [if_pkg::IRQ_ID_WIDTH-1:0]     irq_id_i,
  output logic                                csr_mtvec_init_o,
  // Instruction bus
  output logic                                instr_req_o,
  output logic [if_pkg::XLEN-1:0]             instr_addr_o,
  input  logic                                instr_gnt_i,
  input  logic                                instr_rvalid_i,
  input  logic [if_pkg::XLEN-1:0]             instr_rdata_i,
  input  logic                                instr_err_i,
  // Towards IF/ID stage
  output logic                                fetch_valid_o,
  output logic [if_pkg::XLEN-1:0]             fetch_word_o,
  output logic [if_pkg::XLEN-1:0]             fetch_pc_o,
  output logic                                fetch_err_o,
  input  logic                                fetch_ready_i,
  output logic                                busy_o
);

  logic [if_pkg::XLEN-1:0]              branch_addr_n;
  if_pkg::prefetch_state_e              state_q;
  // Pending bus request belongs to the stream before a redirect
  logic                                 stale_q;
  logic [if_pkg::XLEN-1:0]              req_addr_q;
  logic [if_pkg::XLEN-1:0]              redir_addr_q;
  logic [if_pkg::XLEN-1:0]              resp_pc_q;
  logic [if_pkg::OUTSTND_CNT_WIDTH-1:0] outstnd_cnt_q, outstnd_cnt_n;
  logic [if_pkg::OUTSTND_CNT_WIDTH-1:0] discard_cnt_q, discard_cnt_n;
  logic [if_pkg::OUTSTND_CNT_WIDTH-1:0] buf_cnt_q, buf_cnt_n;
  logic [if_pkg::OUTSTND_CNT_WIDTH-1:0] live_cnt;
  logic [if_pkg::OUTSTND_CNT_WIDTH:0]   inflight;
  logic                                 accept;
  logic                                 resp_live;
  logic                                 consume;
  logic                                 rd_ptr_q, wr_ptr_q;
  logic [if_pkg::XLEN-1:0]              buf_word_q [if_pkg::MAX_OUTSTANDING];
  logic [if_pkg::XLEN-1:0]              buf_pc_q   [if_pkg::MAX_OUTSTANDING];
  logic                                 buf_err_q  [if_pkg::MAX_OUTSTANDING];

  ////////////////////////////////////////////////////////////
  // Next fetch address
  ////////////////////////////////////////////////////////////

  always_comb begin
    branch_addr_n = {boot_addr_i[if_pkg::XLEN-1:2], 2'b00};
    unique case (pc_mux_i)
      if_pkg::PC_BOOT:     branch_addr_n = {boot_addr_i[if_pkg::XLEN-1:2], 2'b00};
      if_pkg::PC_JUMP:     branch_addr_n = jump_target_i;
      if_pkg::PC_BRANCH:   branch_addr_n = branch_target_i;
      if_pkg::PC_MRET:     branch_addr_n = mepc_i;
      // Exceptions share the vector base
      if_pkg::PC_TRAP_EXC: branch_addr_n = {mtvec_addr_i, 7'h00};
      // Interrupts are vectored by id
      if_pkg::PC_TRAP_IRQ: branch_addr_n = {mtvec_addr_i, irq_id_i, 2'b00};
      default: ;
    endcase
  end

  // mtvec init only on boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == if_pkg::PC_BOOT);

  ////////////////////////////////////////////////////////////
  // Bus requests and read tracking
  ////////////////////////////////////////////////////////////

  // Reads that will land in the buffer plus words already there
  assign live_cnt = outstnd_cnt_q - discard_cnt_q;
  assign inflight = {1'b0, live_cnt} + {1'b0, buf_cnt_q};

  assign instr_req_o = (state_q == if_pkg::PF_FETCH) &&
    (outstnd_cnt_q < if_pkg::OUTSTND_CNT_WIDTH'(if_pkg::MAX_OUTSTANDING)) &&
    (inflight < (if_pkg::OUTSTND_CNT_WIDTH+1)'(if_pkg::MAX_OUTSTANDING));
  assign instr_addr_o = req_addr_q;

  assign accept    = instr_req_o && instr_gnt_i;
  // Responses owed to flushed requests never reach the buffer
  assign resp_live = instr_rvalid_i && (discard_cnt_q == '0) && !pc_set_i;
  assign consume   = fetch_valid_o && fetch_ready_i;

  always_comb begin
    outstnd_cnt_n = outstnd_cnt_q + if_pkg::OUTSTND_CNT_WIDTH'(accept)
                  - if_pkg::OUTSTND_CNT_WIDTH'(instr_rvalid_i);
    // Redirect turns every read still owed into a discard
    if (pc_set_i) begin
      discard_cnt_n = outstnd_cnt_n;
    end else begin
      discard_cnt_n = discard_cnt_q + if_pkg::OUTSTND_CNT_WIDTH'(accept && stale_q)
                    - if_pkg::OUTSTND_CNT_WIDTH'(instr_rvalid_i && (discard_cnt_q != '0));
    end
    buf_cnt_n = pc_set_i ? '0 : buf_cnt_q + if_pkg::OUTSTND_CNT_WIDTH'(resp_live)
                              - if_pkg::OUTSTND_CNT_WIDTH'(consume);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= if_pkg::PF_IDLE;
      stale_q       <= 1'b0;
      outstnd_cnt_q <= '0;
      discard_cnt_q <= '0;
      buf_cnt_q     <= '0;
      rd_ptr_q      <= 1'b0;
      wr_ptr_q      <= 1'b0;
    end else begin
      outstnd_cnt_q <= outstnd_cnt_n;
      discard_cnt_q <= discard_cnt_n;
      buf_cnt_q     <= buf_cnt_n;
      if (pc_set_i) begin
        state_q  <= if_pkg::PF_FETCH;
        // A waiting request must finish at its old address
        stale_q  <= instr_req_o && !instr_gnt_i;
        rd_ptr_q <= 1'b0;
        wr_ptr_q <= 1'b0;
      end else begin
        if (accept) stale_q <= 1'b0;
        if (resp_live) wr_ptr_q <= !wr_ptr_q;
        if (consume) rd_ptr_q <= !rd_ptr_q;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Addresses and response buffer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (pc_set_i) begin
      resp_pc_q <= branch_addr_n;
      if (instr_req_o && !instr_gnt_i) redir_addr_q <= branch_addr_n;
      else req_addr_q <= branch_addr_n;
    end else begin
      // Stale grant hands over to the parked target
      if (accept) req_addr_q <= stale_q ? redir_addr_q : req_addr_q + if_pkg::XLEN'(4);
      if (resp_live) begin
        buf_word_q[wr_ptr_q] <= instr_rdata_i;
        buf_pc_q[wr_ptr_q]   <= resp_pc_q;
        buf_err_q[wr_ptr_q]  <= instr_err_i;
        resp_pc_q            <= resp_pc_q + if_pkg::XLEN'(4);
      end
    end
  end

  assign fetch_valid_o = (buf_cnt_q != '0);
  assign fetch_word_o  = buf_word_q[rd_ptr_q];
  assign fetch_pc_o    = buf_pc_q[rd_ptr_q];
  assign fetch_err_o   = buf_err_q[rd_ptr_q];
  assign busy_o        = instr_req_o || (outstnd_cnt_q != '0);

  // Bus never carries more reads than the buffer can absorb
  a_outstnd_max: assert property (@(posedge clk) disable iff (!rst_n)
    outstnd_cnt_q <= if_pkg::OUTSTND_CNT_WIDTH'(if_pkg::MAX_OUTSTANDING));

  // Request holds its address until granted, redirects included
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

/* if_pkg.sv */
// Instruction fetch package
package if_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Address and instruction width
  localparam int XLEN = 32;

  // Trap vector base taken from mtvec
  localparam int MTVEC_ADDR_WIDTH = 25;

  // Interrupt id used for vectoring
  localparam int IRQ_ID_WIDTH = 5;

  // Reads in flight and response buffer depth
  localparam int MAX_OUTSTANDING = 2;
  localparam int OUTSTND_CNT_WIDTH = 2;

  // Dummy frequency setting
  localparam int DUMMY_FREQ_WIDTH = 4;

  ////////////////////////////////////////////////////////////
  // Dummy instruction encoding
  ////////////////////////////////////////////////////////////

  // LFSR reset value and Galois taps
  localparam logic [31:0] LFSR_SEED = 32'hACE1_2468;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // Register-register operation major opcode
  localparam logic [6:0] DUMMY_OPCODE = 7'b0110011;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  // Next fetch address source
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // Prefetcher state
  typedef enum logic {
    PF_IDLE  = 1'b0,
    PF_FETCH = 1'b1
  } prefetch_state_e;

endpackage
